//--- dma_pkg.sv
/* shared package for the DMA adapter: word and field widths, bridge register map,
   register values and the command and register-write structs */
`default_nettype none

package dma_pkg;

    localparam int WORD_W       = 64;
    localparam int BURST_ADDR_W = 25; // address bits 31..7
    localparam int REG_ADDR_W   = 16;
    localparam int REG_DATA_W   = 32;

    // bridge register map
    localparam logic [REG_ADDR_W-1:0] REG_CTRL   = 16'h0200;
    localparam logic [REG_ADDR_W-1:0] REG_LOADDR = 16'h0202;
    localparam logic [REG_ADDR_W-1:0] REG_SIZE   = 16'h0203;
    localparam logic [REG_ADDR_W-1:0] REG_START  = 16'h0204;
    localparam logic [REG_ADDR_W-1:0] REG_LEN    = 16'h0205;
    localparam logic [REG_ADDR_W-1:0] REG_WIDTH  = 16'h0206;
    localparam logic [REG_ADDR_W-1:0] REG_MODE   = 16'h0207;

    localparam logic [REG_DATA_W-1:0] MODE_VAL = 32'd3;
    localparam logic [REG_DATA_W-1:0] CTRL_GO  = 32'd3; // launches one transfer

    // host command, one burst per command
    typedef struct packed {
        logic                    is_write;
        logic [BURST_ADDR_W-1:0] burst_addr;
    } dma_cmd_t;

    // one bridge register write as the serializer sends it
    typedef struct packed {
        logic [REG_ADDR_W-1:0] addr;
        logic [REG_DATA_W-1:0] data;
    } reg_write_t;

endpackage

`default_nettype wire

//--- dma_ctrl.sv
/* command register, busy and bridge setup flag, plus start sequencing of the
   register sequencer and the write and read burst modules */
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl
    import dma_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     cmd_valid,
    input  dma_cmd_t                cmd,
    input  wire                     seq_done,
    input  wire                     wr_done,
    input  wire                     rd_done,
    input  wire                     rdata_done,
    output logic                    cmd_ready,
    output logic [BURST_ADDR_W-1:0] burst_addr,
    output logic                    seq_start,
    output logic                    full_setup,
    output logic                    wr_start,
    output logic                    rd_start,
    output logic                    cmd_wrmem
);

    dma_cmd_t cmd_q;
    logic     accept;
    logic     busy;
    logic     start_q;    // one cycle after acceptance
    logic     bridge_set; // setup registers already written
    logic     seq_seen;
    logic     wr_seen;
    logic     rdata_seen;
    logic     rd_issued;

    assign cmd_ready = ~busy;
    assign accept    = cmd_valid & cmd_ready;

    always_ff @(posedge clk)
    begin
        if (accept)
            cmd_q <= cmd;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy       <= 1'b0;
            start_q    <= 1'b0;
            bridge_set <= 1'b0;
            seq_seen   <= 1'b0;
            wr_seen    <= 1'b0;
            rdata_seen <= 1'b0;
            rd_issued  <= 1'b0;
            rd_start   <= 1'b0;
        end
        else
        begin
            start_q  <= accept;
            rd_start <= 1'b0;
            if (start_q)
                bridge_set <= 1'b1;
            if (accept)
            begin
                busy       <= 1'b1;
                seq_seen   <= 1'b0;
                wr_seen    <= 1'b0;
                rdata_seen <= 1'b0;
                rd_issued  <= 1'b0;
            end
            else if (busy)
            begin
                if (seq_done)
                    seq_seen <= 1'b1;
                if (wr_done)
                    wr_seen <= 1'b1;
                if (rdata_done)
                    rdata_seen <= 1'b1; // bridge buffer filled
                // read data may only move once address and buffer are ready
                if (!cmd_q.is_write && seq_seen && rdata_seen && !rd_issued)
                begin
                    rd_start  <= 1'b1;
                    rd_issued <= 1'b1;
                end
                if (cmd_q.is_write ? (seq_seen && wr_seen) : rd_done)
                    busy <= 1'b0;
            end
        end
    end

    assign burst_addr = cmd_q.burst_addr;
    assign seq_start  = start_q;
    assign full_setup = ~bridge_set; // only the first command after reset
    assign wr_start   = start_q & cmd_q.is_write; // data flows during register writes
    assign cmd_wrmem  = busy & cmd_q.is_write;

endmodule

`default_nettype wire

//--- bridge_reg_sequencer.sv
/* bridge register write sequencer, full setup table or address and control only */
`timescale 1ns/1ps
`default_nettype none

module bridge_reg_sequencer
    import dma_pkg::*;
#(
    parameter int BURST_LEN = 16
)
(
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     seq_start,
    input  wire                     full_setup,
    input  wire  [BURST_ADDR_W-1:0] burst_addr,
    input  wire                     reg_ready,
    output logic                    reg_valid,
    output reg_write_t              reg_wr,
    output logic                    seq_done
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_OFFER = 2'd1;
    localparam logic [1:0] ST_DRAIN = 2'd2; // CTRL accepted, serializer still sending

    localparam logic [2:0] IDX_MODE   = 3'd0;
    localparam logic [2:0] IDX_LOADDR = 3'd5;
    localparam logic [2:0] IDX_CTRL   = 3'd6;

    localparam logic [REG_DATA_W-1:0] LEN_VAL = REG_DATA_W'(BURST_LEN);

    logic [1:0] state;
    logic [2:0] idx;
    logic       taken;

    assign reg_valid = (state == ST_OFFER);
    assign taken     = reg_valid & reg_ready;

    // register table, indexed by step
    always_comb
    begin
        case (idx)
            3'd0:    reg_wr = '{addr: REG_MODE,  data: MODE_VAL};
            3'd1:    reg_wr = '{addr: REG_WIDTH, data: LEN_VAL};
            3'd2:    reg_wr = '{addr: REG_LEN,   data: LEN_VAL};
            3'd3:    reg_wr = '{addr: REG_START, data: '0};
            3'd4:    reg_wr = '{addr: REG_SIZE,  data: LEN_VAL};
            3'd5:    reg_wr = '{addr: REG_LOADDR,
                                data: {{(REG_DATA_W-BURST_ADDR_W){1'b0}}, burst_addr}};
            default: reg_wr = '{addr: REG_CTRL,  data: CTRL_GO};
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= ST_IDLE;
            idx      <= IDX_MODE;
            seq_done <= 1'b0;
        end
        else
        begin
            seq_done <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (seq_start)
                    begin
                        idx   <= full_setup ? IDX_MODE : IDX_LOADDR;
                        state <= ST_OFFER;
                    end
                end
                ST_OFFER:
                begin
                    if (taken)
                    begin
                        if (idx == IDX_CTRL)
                            state <= ST_DRAIN;
                        else
                            idx <= idx + 3'd1;
                    end
                end
                ST_DRAIN:
                begin
                    if (reg_ready)
                    begin
                        seq_done <= 1'b1;
                        state    <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- reg_byte_serializer.sv
/* register write serializer: six bytes on cmd_ad, strobe with the first byte */
`timescale 1ns/1ps
`default_nettype none

module reg_byte_serializer
    import dma_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        reg_valid,
    input  reg_write_t reg_wr,
    output logic       reg_ready,
    output logic [7:0] cmd_ad,
    output logic       cmd_stb
);

    localparam int SHIFT_W = REG_ADDR_W + REG_DATA_W - 8; // bytes after the first

    logic               busy;
    logic               accept;
    logic [2:0]         bytes_left;
    logic [SHIFT_W-1:0] shift_q;

    assign reg_ready = ~busy;
    assign accept    = reg_valid & reg_ready;

    // data bytes follow address bytes, lowest byte first
    always_ff @(posedge clk)
    begin
        if (accept)
            shift_q <= {reg_wr.data, reg_wr.addr[15:8]};
        else if (busy)
            shift_q <= shift_q >> 8;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy       <= 1'b0;
            bytes_left <= 3'd0;
            cmd_ad     <= 8'h00;
            cmd_stb    <= 1'b0;
        end
        else
        begin
            cmd_stb <= 1'b0;
            if (accept)
            begin
                busy       <= 1'b1;
                bytes_left <= 3'd5;
                cmd_ad     <= reg_wr.addr[7:0]; // address low, with strobe
                cmd_stb    <= 1'b1;
            end
            else if (busy)
            begin
                if (bytes_left != 3'd0)
                begin
                    cmd_ad     <= shift_q[7:0];
                    bytes_left <= bytes_left - 3'd1;
                end
                else
                begin
                    cmd_ad <= 8'h00; // sixth byte done
                    busy   <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- wr_burst.sv
/* write burst: host words into the bridge write buffer, page pulses at the end */
`timescale 1ns/1ps
`default_nettype none

module wr_burst
    import dma_pkg::*;
#(
    parameter int BURST_LEN = 16
)
(
    input  wire               clk,
    input  wire               rst,
    input  wire               wr_start,
    input  wire               wr_valid,
    input  wire  [WORD_W-1:0] wr_data,
    output logic              wr_ready,
    output logic              buf_wr,
    output logic [WORD_W-1:0] buf_wdata,
    output logic              buf_wpage_nxt,
    output logic              page_ready_chn,
    output logic              xfer_reset_page_wr,
    output logic              wr_done
);

    localparam int CNT_W = $clog2(BURST_LEN);

    logic             active;
    logic [CNT_W-1:0] cnt;
    logic             accept;
    logic             last;
    logic             last_q;    // last word goes to the buffer this cycle
    logic             page_done;

    assign wr_ready = active;
    assign accept   = wr_valid & wr_ready;
    assign last     = (cnt == CNT_W'(BURST_LEN - 1));

    always_ff @(posedge clk)
    begin
        if (accept)
            buf_wdata <= wr_data;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            active             <= 1'b0;
            cnt                <= '0;
            buf_wr             <= 1'b0;
            last_q             <= 1'b0;
            page_done          <= 1'b0;
            xfer_reset_page_wr <= 1'b0;
        end
        else
        begin
            xfer_reset_page_wr <= wr_start;
            buf_wr             <= accept;
            last_q             <= accept & last;
            page_done          <= last_q; // one cycle after the last buf_wr
            if (wr_start)
            begin
                active <= 1'b1;
                cnt    <= '0;
            end
            else if (accept)
            begin
                cnt <= cnt + 1'b1;
                if (last)
                    active <= 1'b0;
            end
        end
    end

    assign buf_wpage_nxt  = page_done;
    assign page_ready_chn = page_done;
    assign wr_done        = page_done;

endmodule

`default_nettype wire

//--- rd_burst.sv
/* read burst: words fetched from the bridge read buffer and held for the host */
`timescale 1ns/1ps
`default_nettype none

module rd_burst
    import dma_pkg::*;
#(
    parameter int BURST_LEN = 16
)
(
    input  wire               clk,
    input  wire               rst,
    input  wire               rd_start,
    input  wire  [WORD_W-1:0] buf_rdata,
    input  wire               rd_ready,
    output logic              buf_rd,
    output logic              rd_valid,
    output logic [WORD_W-1:0] rd_data,
    output logic              buf_rpage_nxt,
    output logic              xfer_reset_page_rd,
    output logic              rd_done
);

    localparam int CNT_W = $clog2(BURST_LEN);

    localparam logic [2:0] ST_IDLE  = 3'd0;
    localparam logic [2:0] ST_PAGE  = 3'd1; // page reset pulse
    localparam logic [2:0] ST_FETCH = 3'd2;
    localparam logic [2:0] ST_CAPT  = 3'd3; // buf_rdata valid here
    localparam logic [2:0] ST_HOLD  = 3'd4;

    logic [2:0]       state;
    logic [CNT_W-1:0] cnt;

    assign xfer_reset_page_rd = (state == ST_PAGE);
    assign buf_rd             = (state == ST_FETCH);
    assign rd_valid           = (state == ST_HOLD);

    always_ff @(posedge clk)
    begin
        if (state == ST_CAPT)
            rd_data <= buf_rdata;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state         <= ST_IDLE;
            cnt           <= '0;
            buf_rpage_nxt <= 1'b0;
            rd_done       <= 1'b0;
        end
        else
        begin
            buf_rpage_nxt <= 1'b0;
            rd_done       <= 1'b0;
            case (state)
                ST_IDLE:  if (rd_start) state <= ST_PAGE;
                ST_PAGE:
                begin
                    cnt   <= '0;
                    state <= ST_FETCH;
                end
                ST_FETCH: state <= ST_CAPT;
                ST_CAPT:  state <= ST_HOLD;
                ST_HOLD:
                begin
                    if (rd_ready)
                    begin
                        if (cnt == CNT_W'(BURST_LEN - 1))
                        begin
                            buf_rpage_nxt <= 1'b1;
                            rd_done       <= 1'b1;
                            state         <= ST_IDLE;
                        end
                        else
                        begin
                            cnt   <= cnt + 1'b1;
                            state <= ST_FETCH; // next word
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- dma_adapter.sv
/* DMA adapter top level: control, register sequencer and serializer,
   write and read burst modules */
`timescale 1ns/1ps
`default_nettype none

module dma_adapter
    import dma_pkg::*;
#(
    parameter int BURST_LEN = 16
)
(
    input  wire               clk,
    input  wire               rst,
    input  wire               cmd_valid,
    input  dma_cmd_t          cmd,
    input  wire               wr_valid,
    input  wire  [WORD_W-1:0] wr_data,
    input  wire               rd_ready,
    input  wire  [WORD_W-1:0] buf_rdata,
    input  wire               rdata_done,
    output logic              cmd_ready,
    output logic              wr_ready,
    output logic              rd_valid,
    output logic [WORD_W-1:0] rd_data,
    output logic [7:0]        cmd_ad,
    output logic              cmd_stb,
    output logic              cmd_wrmem,
    output logic              page_ready_chn,
    output logic              xfer_reset_page_wr,
    output logic              buf_wpage_nxt,
    output logic              buf_wr,
    output logic [WORD_W-1:0] buf_wdata,
    output logic              xfer_reset_page_rd,
    output logic              buf_rpage_nxt,
    output logic              buf_rd
);

    logic [BURST_ADDR_W-1:0] burst_addr;
    logic                    seq_start;
    logic                    full_setup;
    logic                    seq_done;
    logic                    wr_start;
    logic                    wr_done;
    logic                    rd_start;
    logic                    rd_done;
    logic                    reg_valid;
    logic                    reg_ready;
    reg_write_t              reg_wr;

    dma_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .seq_done   (seq_done),
        .wr_done    (wr_done),
        .rd_done    (rd_done),
        .rdata_done (rdata_done),
        .cmd_ready  (cmd_ready),
        .burst_addr (burst_addr),
        .seq_start  (seq_start),
        .full_setup (full_setup),
        .wr_start   (wr_start),
        .rd_start   (rd_start),
        .cmd_wrmem  (cmd_wrmem)
    );

    bridge_reg_sequencer #(.BURST_LEN(BURST_LEN)) u_seq (
        .clk        (clk),
        .rst        (rst),
        .seq_start  (seq_start),
        .full_setup (full_setup),
        .burst_addr (burst_addr),
        .reg_ready  (reg_ready),
        .reg_valid  (reg_valid),
        .reg_wr     (reg_wr),
        .seq_done   (seq_done)
    );

    reg_byte_serializer u_ser (
        .clk       (clk),
        .rst       (rst),
        .reg_valid (reg_valid),
        .reg_wr    (reg_wr),
        .reg_ready (reg_ready),
        .cmd_ad    (cmd_ad),
        .cmd_stb   (cmd_stb)
    );

    wr_burst #(.BURST_LEN(BURST_LEN)) u_wr (
        .clk                (clk),
        .rst                (rst),
        .wr_start           (wr_start),
        .wr_valid           (wr_valid),
        .wr_data            (wr_data),
        .wr_ready           (wr_ready),
        .buf_wr             (buf_wr),
        .buf_wdata          (buf_wdata),
        .buf_wpage_nxt      (buf_wpage_nxt),
        .page_ready_chn     (page_ready_chn),
        .xfer_reset_page_wr (xfer_reset_page_wr),
        .wr_done            (wr_done)
    );

    rd_burst #(.BURST_LEN(BURST_LEN)) u_rd (
        .clk                (clk),
        .rst                (rst),
        .rd_start           (rd_start),
        .buf_rdata          (buf_rdata),
        .rd_ready           (rd_ready),
        .buf_rd             (buf_rd),
        .rd_valid           (rd_valid),
        .rd_data            (rd_data),
        .buf_rpage_nxt      (buf_rpage_nxt),
        .xfer_reset_page_rd (xfer_reset_page_rd),
        .rd_done            (rd_done)
    );

endmodule

`default_nettype wire

//--- tb_dma_adapter.sv
/* testbench for the DMA adapter with bridge model, directed write, read and busy tests,
   compare tasks and a cycle limit */
`timescale 1ns/1ps
`default_nettype none

module tb_dma_adapter
    import dma_pkg::*;
();

    localparam int BURST_LEN   = 16;
    localparam int CYCLE_LIMIT = 3000; // five bursts need well under 500 cycles

    logic              clk;
    logic              rst;
    logic              cmd_valid;
    dma_cmd_t          cmd;
    logic              wr_valid;
    logic [WORD_W-1:0] wr_data;
    logic              rd_ready;
    logic [WORD_W-1:0] buf_rdata;
    logic              rdata_done;
    logic              cmd_ready;
    logic              wr_ready;
    logic              rd_valid;
    logic [WORD_W-1:0] rd_data;
    logic [7:0]        cmd_ad;
    logic              cmd_stb;
    logic              cmd_wrmem;
    logic              page_ready_chn;
    logic              xfer_reset_page_wr;
    logic              buf_wpage_nxt;
    logic              buf_wr;
    logic [WORD_W-1:0] buf_wdata;
    logic              xfer_reset_page_rd;
    logic              buf_rpage_nxt;
    logic              buf_rd;

    integer            seed = 74;
    int                errors;
    int                checks;
    int                n_pass;
    int                n_fail;
    int                cycles;
    int                exp_total;   // register writes expected over the run

    // bridge model state
    reg_write_t        reg_q[$];
    logic [WORD_W-1:0] wq[$];
    logic [7:0]        frame [0:5];
    reg_write_t        rw;
    int                byte_cnt;
    int                n_stb;
    int                n_pg_wr;
    int                n_wpage;
    int                n_prdy;
    int                n_pg_rd;
    int                n_rpage;
    int                rd_ptr;
    int                rdone_wait;
    logic              fire;
    logic              rdone_seen;  // read buffer reported filled
    logic [WORD_W-1:0] next_rdata;
    logic [WORD_W-1:0] rd_mem    [0:BURST_LEN-1];
    logic [WORD_W-1:0] exp_words [0:BURST_LEN-1];
    logic [WORD_W-1:0] got_words [0:BURST_LEN-1];

    dma_adapter #(.BURST_LEN(BURST_LEN)) uut (
        .clk                (clk),
        .rst                (rst),
        .cmd_valid          (cmd_valid),
        .cmd                (cmd),
        .wr_valid           (wr_valid),
        .wr_data            (wr_data),
        .rd_ready           (rd_ready),
        .buf_rdata          (buf_rdata),
        .rdata_done         (rdata_done),
        .cmd_ready          (cmd_ready),
        .wr_ready           (wr_ready),
        .rd_valid           (rd_valid),
        .rd_data            (rd_data),
        .cmd_ad             (cmd_ad),
        .cmd_stb            (cmd_stb),
        .cmd_wrmem          (cmd_wrmem),
        .page_ready_chn     (page_ready_chn),
        .xfer_reset_page_wr (xfer_reset_page_wr),
        .buf_wpage_nxt      (buf_wpage_nxt),
        .buf_wr             (buf_wr),
        .buf_wdata          (buf_wdata),
        .xfer_reset_page_rd (xfer_reset_page_rd),
        .buf_rpage_nxt      (buf_rpage_nxt),
        .buf_rd             (buf_rd)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // bridge model with byte assembly, write buffer capture and read buffer answers
    always @(posedge clk)
    begin
        fire = 1'b0;
        if (rst)
        begin
            byte_cnt   = 0;
            rd_ptr     = 0;
            rdone_wait = 0;
            rdone_seen = 1'b0;
        end
        else
        begin
            if (cmd_stb)
            begin
                if (byte_cnt != 0)
                begin
                    errors++;
                    $display("framing error: strobe after only %0d bytes of a register write",
                             byte_cnt);
                end
                n_stb++;
                frame[0] = cmd_ad; // address low
                byte_cnt = 1;
            end
            else if (byte_cnt != 0)
            begin
                frame[byte_cnt] = cmd_ad;
                byte_cnt++;
                if (byte_cnt == 6)
                begin
                    rw.addr = {frame[1], frame[0]};
                    rw.data = {frame[5], frame[4], frame[3], frame[2]};
                    reg_q.push_back(rw);
                    byte_cnt = 0;
                    if (rw.addr == REG_CTRL && !cmd_wrmem && !cmd_ready)
                        rdone_wait = 8; // read buffer fills a little later
                end
            end
            if (buf_wr)
                wq.push_back(buf_wdata);
            if (xfer_reset_page_wr)
                n_pg_wr++;
            if (buf_wpage_nxt)
                n_wpage++;
            if (page_ready_chn)
                n_prdy++;
            if (buf_rpage_nxt)
                n_rpage++;
            if (xfer_reset_page_rd)
            begin
                n_pg_rd++;
                rd_ptr = 0;
            end
            if (buf_rd)
            begin
                if (!rdone_seen)
                begin
                    errors++;
                    $display("read buffer fetched before rdata_done was given");
                end
                next_rdata = rd_mem[rd_ptr % BURST_LEN];
                rd_ptr++;
            end
            if (rdone_wait != 0)
            begin
                rdone_wait--;
                fire = (rdone_wait == 0);
                if (fire)
                    rdone_seen = 1'b1;
            end
        end
        #1;
        buf_rdata  = next_rdata;
        rdata_done = fire;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic check_reg_write(input string name, input reg_write_t exp,
                                   input reg_write_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("MISMATCH %s: expected addr %h data %h, actual addr %h data %h",
                     name, exp.addr, exp.data, act.addr, act.data);
        end
    endtask

    task automatic check_word(input string name, input logic [WORD_W-1:0] exp,
                              input logic [WORD_W-1:0] act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic expect_once(input string name, input string what, input int count);
        checks++;
        if (count != 1)
        begin
            errors++;
            $display("%s: %s pulsed %0d times instead of once", name, what, count);
        end
    endtask

    function automatic reg_write_t make_reg(input logic [REG_ADDR_W-1:0] a,
                                            input logic [REG_DATA_W-1:0] d);
        reg_write_t r;
        r.addr = a;
        r.data = d;
        return r;
    endfunction

    task automatic clear_model();
        reg_q.delete();
        wq.delete();
        n_pg_wr    = 0;
        n_wpage    = 0;
        n_prdy     = 0;
        n_pg_rd    = 0;
        n_rpage    = 0;
        rdone_seen = 1'b0;
    endtask

    task automatic issue_cmd(input dma_cmd_t c, input bit hold);
        cmd       = c;
        cmd_valid = 1'b1;
        @(posedge clk);
        while (!cmd_ready)
            @(posedge clk);
        #1;
        if (!hold)
            cmd_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (!cmd_ready)
        begin
            @(posedge clk);
            #1;
        end
        repeat (4) @(posedge clk); // let the last frame and pulses settle
        #1;
    endtask

    // expected register table for one command
    task automatic compare_regs(input string name, input bit full,
                                input logic [BURST_ADDR_W-1:0] addr);
        reg_write_t exp[$];
        if (full)
        begin
            exp.push_back(make_reg(REG_MODE, MODE_VAL));
            exp.push_back(make_reg(REG_WIDTH, BURST_LEN));
            exp.push_back(make_reg(REG_LEN, BURST_LEN));
            exp.push_back(make_reg(REG_START, 0));
            exp.push_back(make_reg(REG_SIZE, BURST_LEN));
        end
        exp.push_back(make_reg(REG_LOADDR, {7'd0, addr}));
        exp.push_back(make_reg(REG_CTRL, CTRL_GO));
        exp_total += exp.size();
        checks++;
        if (reg_q.size() != exp.size())
        begin
            errors++;
            $display("%s: expected %0d register writes, saw %0d", name, exp.size(),
                     reg_q.size());
        end
        else
        begin
            foreach (exp[i])
                check_reg_write(name, exp[i], reg_q[i]);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before)
        begin
            n_pass++;
            $display("PASS %s", name);
        end
        else
        begin
            n_fail++;
            $display("FAIL %s (%0d errors)", name, errors - err_before);
        end
    endtask

    task automatic after_reset();
        int err_before;
        err_before = errors;
        check_bit("after_reset cmd_ready", 1'b1, cmd_ready);
        check_bit("after_reset cmd_stb", 1'b0, cmd_stb);
        check_bit("after_reset buf_wr", 1'b0, buf_wr);
        check_bit("after_reset buf_rd", 1'b0, buf_rd);
        check_bit("after_reset rd_valid", 1'b0, rd_valid);
        check_bit("after_reset wr_ready", 1'b0, wr_ready);
        check_bit("after_reset cmd_wrmem", 1'b0, cmd_wrmem);
        check_bit("after_reset buf_wpage_nxt", 1'b0, buf_wpage_nxt);
        check_bit("after_reset buf_rpage_nxt", 1'b0, buf_rpage_nxt);
        report_test("after_reset", err_before);
    endtask

    task automatic write_burst(input string name, input logic [BURST_ADDR_W-1:0] addr,
                               input bit full, input bit hold);
        int       err_before;
        int       idx;
        logic     wrmem_seen;
        logic     ready_seen;
        dma_cmd_t c;
        err_before = errors;
        wrmem_seen = 1'b0;
        ready_seen = 1'b1;
        clear_model();
        for (int i = 0; i < BURST_LEN; i++)
            exp_words[i] = {$random(seed), $random(seed)};
        c.is_write   = 1'b1;
        c.burst_addr = addr;
        issue_cmd(c, hold);
        idx = 0;
        while (idx < BURST_LEN)
        begin
            wr_valid = ($random(seed) & 3) != 0; // gaps about one cycle in four
            wr_data  = exp_words[idx];
            @(posedge clk);
            if (wr_valid && wr_ready)
            begin
                if (idx == 0)
                begin
                    wrmem_seen = cmd_wrmem;
                    ready_seen = cmd_ready;
                end
                idx++;
            end
            #1;
        end
        wr_valid  = 1'b0;
        cmd_valid = 1'b0;
        wait_idle();
        compare_regs(name, full, addr);
        checks++;
        if (wq.size() != BURST_LEN)
        begin
            errors++;
            $display("%s: expected %0d buffer writes, saw %0d", name, BURST_LEN, wq.size());
        end
        else
        begin
            for (int i = 0; i < BURST_LEN; i++)
                check_word(name, exp_words[i], wq[i]);
        end
        expect_once(name, "xfer_reset_page_wr", n_pg_wr);
        expect_once(name, "buf_wpage_nxt", n_wpage);
        expect_once(name, "page_ready_chn", n_prdy);
        check_bit(name, 1'b1, wrmem_seen);
        check_bit(name, 1'b0, ready_seen); // busy while the words move
        report_test(name, err_before);
    endtask

    task automatic read_burst(input string name, input logic [BURST_ADDR_W-1:0] addr);
        int       err_before;
        int       idx;
        logic     wrmem_seen;
        dma_cmd_t c;
        err_before = errors;
        wrmem_seen = 1'b1;
        clear_model();
        for (int i = 0; i < BURST_LEN; i++)
            rd_mem[i] = {$random(seed), $random(seed)};
        c.is_write   = 1'b0;
        c.burst_addr = addr;
        issue_cmd(c, 1'b0);
        idx = 0;
        while (idx < BURST_LEN)
        begin
            rd_ready = ($random(seed) & 3) != 0;
            @(posedge clk);
            if (rd_valid && rd_ready)
            begin
                got_words[idx] = rd_data;
                if (idx == 0)
                    wrmem_seen = cmd_wrmem;
                idx++;
            end
            #1;
        end
        rd_ready = 1'b0;
        wait_idle();
        compare_regs(name, 1'b0, addr);
        for (int i = 0; i < BURST_LEN; i++)
            check_word(name, rd_mem[i], got_words[i]);
        expect_once(name, "xfer_reset_page_rd", n_pg_rd);
        expect_once(name, "buf_rpage_nxt", n_rpage);
        check_bit(name, 1'b0, wrmem_seen);
        report_test(name, err_before);
    endtask

    task automatic byte_framing();
        int err_before;
        err_before = errors;
        checks++;
        if (n_stb != exp_total || byte_cnt != 0)
        begin
            errors++;
            $display("byte_framing: %0d strobes for %0d register writes, %0d bytes left over",
                     n_stb, exp_total, byte_cnt);
        end
        report_test("byte_framing", err_before);
    endtask

    initial
    begin
        rst        = 1'b1;
        cmd_valid  = 1'b0;
        cmd        = '0;
        wr_valid   = 1'b0;
        wr_data    = '0;
        rd_ready   = 1'b0;
        buf_rdata  = '0;
        rdata_done = 1'b0;
        next_rdata = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        after_reset();
        write_burst("first_write", 25'h1A2B3C4, 1'b1, 1'b0);
        write_burst("second_write", 25'h0055AA1, 1'b0, 1'b0);
        read_burst("read", 25'h1F00F0F);
        write_burst("write_valid_held", 25'h0000080, 1'b0, 1'b1);
        read_burst("read_after_held", 25'h1234567);
        byte_framing();
        $display("tests: %0d passed, %0d failed; checks: %0d; errors: %0d",
                 n_pass, n_fail, checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
dma_pkg.sv
dma_ctrl.sv
bridge_reg_sequencer.sv
reg_byte_serializer.sv
wr_burst.sv
rd_burst.sv
dma_adapter.sv
tb_dma_adapter.sv
